// File: verilog/spi_pkg.sv
`default_nettype none

package spi_pkg;

    // sizes
    localparam int DATA_W         = 32;
    localparam int ADDR_W         = 8;
    localparam int FIFO_DEPTH     = 4;
    localparam int FIFO_PTR_W     = $clog2(FIFO_DEPTH);
    localparam int FIFO_LVL_W     = 3;    // level runs 0..4
    localparam int CHAR_W         = 8;
    localparam int CHARS_PER_WORD = 4;
    localparam int NCS            = 4;
    localparam int CS_W           = 2;
    localparam int TRANLEN_W      = 4;    // characters minus one
    localparam int PM_W           = 4;

    // register map, byte addresses
    localparam logic [ADDR_W-1:0] ADDR_SPMODE  = 8'h00;
    localparam logic [ADDR_W-1:0] ADDR_SPSTAT  = 8'h04;
    localparam logic [ADDR_W-1:0] ADDR_SPCOM   = 8'h08;
    localparam logic [ADDR_W-1:0] ADDR_SPITF   = 8'h0C;
    localparam logic [ADDR_W-1:0] ADDR_SPIRF   = 8'h10;
    localparam logic [ADDR_W-1:0] ADDR_CSMODE0 = 8'h20;   // CSMODE1..3 every 4 bytes after

    // field positions
    localparam int SPMODE_EN        = 31;
    localparam int SPCOM_CS_HI      = 31;
    localparam int SPCOM_CS_LO      = 30;
    localparam int SPCOM_TRANLEN_HI = 3;
    localparam int SPCOM_TRANLEN_LO = 0;
    localparam int CSMODE_CPOL      = 31;
    localparam int CSMODE_CPHA      = 30;
    localparam int CSMODE_PM_HI     = 19;
    localparam int CSMODE_PM_LO     = 16;
    localparam int SPSTAT_BUSY      = 31;
    localparam int SPSTAT_RXLVL_LO  = 8;
    localparam int SPSTAT_TXLVL_LO  = 0;

    localparam logic [DATA_W-1:0] SPMODE_RST = 32'h0000_100F;   // enable clear
    localparam logic [DATA_W-1:0] CSMODE_RST = 32'h0010_0000;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// File: verilog/spi_axil_slave.sv
`timescale 1ns/100ps
`default_nettype none

module spi_axil_slave
    import spi_pkg::*;
(
    input  wire logic              S_SYSCLK,
    input  wire logic              S_RESETN,
    input  wire logic [ADDR_W-1:0] awaddr,
    input  wire logic              awvalid,
    output logic                   awready,
    input  wire logic [DATA_W-1:0] wdata,
    input  wire logic [3:0]        wstrb,
    input  wire logic              wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  wire logic              bready,
    input  wire logic [ADDR_W-1:0] araddr,
    input  wire logic              arvalid,
    output logic                   arready,
    output logic [DATA_W-1:0]      rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  wire logic              rready,
    output logic                   wr_en,
    output logic [ADDR_W-1:0]      wr_addr,
    output logic [DATA_W-1:0]      wr_data,
    output logic [3:0]             wr_strb,
    input  wire logic              wr_err,
    output logic                   rd_en,
    output logic [ADDR_W-1:0]      rd_addr,
    input  wire logic [DATA_W-1:0] rd_data,
    input  wire logic              rd_err
);

    logic aw_take;
    logic ar_take;

    // one transfer in flight per direction
    assign aw_take = awvalid && wvalid && !awready && !bvalid;
    assign ar_take = arvalid && !arready && !rvalid;

    assign wr_en   = awready && wready;   // the handshake cycle
    assign wr_data = wdata;
    assign wr_strb = wstrb;
    assign rd_en   = arready;

    always_ff @(posedge S_SYSCLK or negedge S_RESETN)
    begin
        if (!S_RESETN)
        begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end
        else
        begin
            awready <= aw_take;
            wready  <= aw_take;
            arready <= ar_take;
            if (wr_en)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            if (rd_en)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // addresses and responses
    always_ff @(posedge S_SYSCLK)
    begin
        if (aw_take)
            wr_addr <= awaddr;
        if (wr_en)
            bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
        if (ar_take)
            rd_addr <= araddr;
        if (rd_en)
        begin
            rdata <= rd_data;
            rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

endmodule

`default_nettype wire

// File: verilog/spi_regs.sv
`timescale 1ns/100ps
`default_nettype none

module spi_regs
    import spi_pkg::*;
(
    input  wire logic                  S_SYSCLK,
    input  wire logic                  S_RESETN,
    input  wire logic                  wr_en,
    input  wire logic [ADDR_W-1:0]     wr_addr,
    input  wire logic [DATA_W-1:0]     wr_data,
    input  wire logic [3:0]            wr_strb,
    output logic                       wr_err,
    input  wire logic                  rd_en,
    input  wire logic [ADDR_W-1:0]     rd_addr,
    output logic [DATA_W-1:0]          rd_data,
    output logic                       rd_err,
    output logic                       tx_push,
    input  wire logic                  tx_full,
    input  wire logic [FIFO_LVL_W-1:0] tx_level,
    output logic                       rx_pop,
    input  wire logic                  rx_empty,
    input  wire logic [FIFO_LVL_W-1:0] rx_level,
    input  wire logic [DATA_W-1:0]     rx_word,
    input  wire logic                  busy,
    output logic                       frame_start,
    output logic [CS_W-1:0]            cs_sel,
    output logic [TRANLEN_W-1:0]       tranlen,
    output logic                       enable,
    output logic                       cpol,
    output logic                       cpha,
    output logic [PM_W-1:0]            pm
);

    logic [DATA_W-1:0] spmode;
    logic [DATA_W-1:0] spcom;
    logic [DATA_W-1:0] csmode [NCS];
    logic [DATA_W-1:0] cur_csmode;
    logic [DATA_W-1:0] spstat;
    logic              hit_spmode;
    logic              hit_spcom;
    logic              hit_spitf;
    logic              hit_cs;
    logic              start_ok;

    function automatic logic [DATA_W-1:0] strb_merge(
        input logic [DATA_W-1:0] old_val,
        input logic [DATA_W-1:0] new_val,
        input logic [3:0]        strb
    );
        logic [DATA_W-1:0] res;
        res = old_val;
        for (int i = 0; i < 4; i++)
        begin
            if (strb[i])
                res[i*8 +: 8] = new_val[i*8 +: 8];
        end
        return res;
    endfunction

    assign hit_spmode = wr_addr[ADDR_W-1:2] == ADDR_SPMODE[ADDR_W-1:2];
    assign hit_spcom  = wr_addr[ADDR_W-1:2] == ADDR_SPCOM[ADDR_W-1:2];
    assign hit_spitf  = wr_addr[ADDR_W-1:2] == ADDR_SPITF[ADDR_W-1:2];
    assign hit_cs     = wr_addr[ADDR_W-1:4] == ADDR_CSMODE0[ADDR_W-1:4];

    assign wr_err   = !(hit_spmode || hit_spcom || hit_cs || (hit_spitf && !tx_full));
    assign tx_push  = wr_en && hit_spitf && !tx_full;
    assign start_ok = wr_en && hit_spcom && enable && !busy;   // otherwise dropped

    always_ff @(posedge S_SYSCLK or negedge S_RESETN)
    begin
        if (!S_RESETN)
        begin
            spmode      <= SPMODE_RST;
            spcom       <= '0;
            frame_start <= 1'b0;
            for (int i = 0; i < NCS; i++)
                csmode[i] <= CSMODE_RST;
        end
        else
        begin
            frame_start <= start_ok;   // spcom already holds the new command
            if (wr_en && hit_spmode)
                spmode <= strb_merge(spmode, wr_data, wr_strb);
            if (start_ok)
                spcom <= strb_merge(spcom, wr_data, wr_strb);
            if (wr_en && hit_cs)
                csmode[wr_addr[CS_W+1:2]] <= strb_merge(csmode[wr_addr[CS_W+1:2]],
                                                        wr_data, wr_strb);
        end
    end

    always_comb
    begin
        spstat = '0;
        spstat[SPSTAT_BUSY] = busy;
        spstat[SPSTAT_RXLVL_LO +: FIFO_LVL_W] = rx_level;
        spstat[SPSTAT_TXLVL_LO +: FIFO_LVL_W] = tx_level;
    end

    // read mux
    always_comb
    begin
        rd_data = '0;
        rd_err  = 1'b0;
        rx_pop  = 1'b0;
        if (rd_addr[ADDR_W-1:4] == ADDR_CSMODE0[ADDR_W-1:4])
            rd_data = csmode[rd_addr[CS_W+1:2]];
        else
        begin
            case (rd_addr[ADDR_W-1:2])
                ADDR_SPMODE[ADDR_W-1:2]: rd_data = spmode;
                ADDR_SPSTAT[ADDR_W-1:2]: rd_data = spstat;
                ADDR_SPCOM[ADDR_W-1:2]:  rd_data = spcom;
                ADDR_SPIRF[ADDR_W-1:2]:
                begin
                    rd_data = rx_empty ? '0 : rx_word;
                    rd_err  = rx_empty;
                    rx_pop  = rd_en && !rx_empty;
                end
                default: rd_err = 1'b1;
            endcase
        end
    end

    // mode of the chip select held in SPCOM
    assign enable     = spmode[SPMODE_EN];
    assign cs_sel     = spcom[SPCOM_CS_HI:SPCOM_CS_LO];
    assign tranlen    = spcom[SPCOM_TRANLEN_HI:SPCOM_TRANLEN_LO];
    assign cur_csmode = csmode[cs_sel];
    assign cpol       = cur_csmode[CSMODE_CPOL];
    assign cpha       = cur_csmode[CSMODE_CPHA];
    assign pm         = cur_csmode[CSMODE_PM_HI:CSMODE_PM_LO];

endmodule

`default_nettype wire

// File: verilog/spi_word_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module spi_word_fifo
    import spi_pkg::*;
(
    input  wire logic              S_SYSCLK,
    input  wire logic              S_RESETN,
    input  wire logic              push,
    input  wire logic [DATA_W-1:0] push_data,
    input  wire logic              pop,
    output logic [DATA_W-1:0]      pop_data,
    output logic                   full,
    output logic                   empty,
    output logic [FIFO_LVL_W-1:0]  level
);

    logic [DATA_W-1:0]     mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic                  do_push;
    logic                  do_pop;

    assign full     = level == FIFO_LVL_W'(FIFO_DEPTH);
    assign empty    = level == '0;
    assign do_push  = push && !full;   // dropped when full
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];     // head word

    always_ff @(posedge S_SYSCLK or negedge S_RESETN)
    begin
        if (!S_RESETN)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            level <= level + FIFO_LVL_W'(do_push) - FIFO_LVL_W'(do_pop);
        end
    end

    always_ff @(posedge S_SYSCLK)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

endmodule

`default_nettype wire

// File: verilog/spi_frame_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module spi_frame_ctrl
    import spi_pkg::*;
(
    input  wire logic                 S_SYSCLK,
    input  wire logic                 S_RESETN,
    input  wire logic                 frame_start,
    input  wire logic [CS_W-1:0]      cs_sel,
    input  wire logic [TRANLEN_W-1:0] tranlen,
    input  wire logic                 enable,
    output logic                      busy,
    output logic                      tx_pop,
    input  wire logic                 tx_empty,
    input  wire logic [DATA_W-1:0]    tx_word,
    output logic                      rx_push,
    input  wire logic                 rx_full,
    output logic [DATA_W-1:0]         rx_word_out,
    output logic                      char_go,
    output logic [CHAR_W-1:0]         tx_char,
    input  wire logic                 char_done,
    input  wire logic [CHAR_W-1:0]    rx_char,
    output logic [NCS-1:0]            spi_cs_b
);

    logic [TRANLEN_W-1:0]                  chars_left;   // after the one in flight
    logic [$clog2(CHARS_PER_WORD)-1:0]     byte_idx;
    logic [DATA_W-1:0]                     tx_buf;
    logic                                  tx_valid;     // tx_buf has bytes left
    logic                                  in_char;
    logic                                  last;         // all characters done
    logic [DATA_W-1:0]                     rx_pack;
    logic [$clog2(CHARS_PER_WORD+1)-1:0]   rx_cnt;

    // fetch only between characters so no word of a later frame is taken
    assign tx_pop  = busy && !tx_valid && !in_char && !last && !tx_empty;
    assign char_go = busy && tx_valid && !in_char && !last && rx_cnt != CHARS_PER_WORD;
    assign tx_char = tx_buf[DATA_W-1-CHAR_W*byte_idx -: CHAR_W];   // 31:24 first

    assign rx_push     = busy && !rx_full &&
                         (rx_cnt == CHARS_PER_WORD || (last && rx_cnt != '0));
    assign rx_word_out = rx_pack << (CHAR_W * (CHARS_PER_WORD - rx_cnt));   // left-aligned

    always_ff @(posedge S_SYSCLK or negedge S_RESETN)
    begin
        if (!S_RESETN)
        begin
            busy       <= 1'b0;
            spi_cs_b   <= '1;
            chars_left <= '0;
            byte_idx   <= '0;
            tx_valid   <= 1'b0;
            in_char    <= 1'b0;
            last       <= 1'b0;
            rx_cnt     <= '0;
        end
        else
        begin
            // an aborted character still runs to its end in the shifter
            if (char_done)
                in_char <= 1'b0;
            else if (char_go)
                in_char <= 1'b1;

            if (!enable || (rx_push && last))
            begin
                busy     <= 1'b0;
                spi_cs_b <= '1;
                last     <= 1'b0;
            end
            else if (frame_start)
            begin
                busy       <= 1'b1;
                spi_cs_b   <= ~(NCS'(1) << cs_sel);
                chars_left <= tranlen;
                byte_idx   <= '0;
                tx_valid   <= 1'b0;
                rx_cnt     <= '0;
            end
            else if (busy)
            begin
                if (tx_pop)
                    tx_valid <= 1'b1;
                if (char_go)
                begin
                    byte_idx <= byte_idx + 1'b1;
                    if (byte_idx == CHARS_PER_WORD - 1)
                        tx_valid <= 1'b0;
                end
                if (char_done)
                begin
                    rx_cnt <= rx_cnt + 1'b1;
                    if (chars_left == '0)
                        last <= 1'b1;
                    else
                        chars_left <= chars_left - 1'b1;
                end
                if (rx_push)
                    rx_cnt <= '0;
            end
        end
    end

    always_ff @(posedge S_SYSCLK)
    begin
        if (tx_pop)
            tx_buf <= tx_word;
        if (char_done)
            rx_pack <= {rx_pack[DATA_W-CHAR_W-1:0], rx_char};
    end

endmodule

`default_nettype wire

// File: verilog/spi_char_shifter.sv
`timescale 1ns/100ps
`default_nettype none

module spi_char_shifter
    import spi_pkg::*;
(
    input  wire logic              S_SYSCLK,
    input  wire logic              S_RESETN,
    input  wire logic              cpol,
    input  wire logic              cpha,
    input  wire logic [PM_W-1:0]   pm,
    input  wire logic              char_go,
    input  wire logic [CHAR_W-1:0] tx_char,
    output logic                   char_done,
    output logic [CHAR_W-1:0]      rx_char,
    output logic                   spi_sck,
    output logic                   spi_mosi,
    input  wire logic              spi_miso
);

    logic                            active;
    logic [PM_W-1:0]                 div_cnt;
    logic [$clog2(2*CHAR_W)-1:0]     half_cnt;   // even is the leading edge
    logic [CHAR_W-1:0]               tx_sh;      // next bit out at msb
    logic                            tick;
    logic                            shift_edge;

    assign tick       = active && div_cnt == pm;   // end of a half period
    assign shift_edge = half_cnt[0] != cpha;       // cpha 0 shifts on trailing

    always_ff @(posedge S_SYSCLK or negedge S_RESETN)
    begin
        if (!S_RESETN)
        begin
            active    <= 1'b0;
            div_cnt   <= '0;
            half_cnt  <= '0;
            spi_sck   <= 1'b0;
            char_done <= 1'b0;
        end
        else
        begin
            char_done <= tick && half_cnt == 2*CHAR_W - 1;
            if (!active)
            begin
                spi_sck  <= cpol;   // idle level
                div_cnt  <= '0;
                half_cnt <= '0;
                active   <= char_go;
            end
            else if (tick)
            begin
                spi_sck  <= ~spi_sck;
                div_cnt  <= '0;
                half_cnt <= half_cnt + 1'b1;
                if (half_cnt == 2*CHAR_W - 1)
                    active <= 1'b0;
            end
            else
                div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge S_SYSCLK)
    begin
        if (!active && char_go)
        begin
            tx_sh <= cpha ? tx_char : {tx_char[CHAR_W-2:0], 1'b0};
            if (!cpha)
                spi_mosi <= tx_char[CHAR_W-1];   // ahead of the first edge
        end
        else if (tick && shift_edge)
        begin
            spi_mosi <= tx_sh[CHAR_W-1];
            tx_sh    <= tx_sh << 1;
        end
        else if (tick)
            rx_char <= {rx_char[CHAR_W-2:0], spi_miso};
    end

endmodule

`default_nettype wire

// File: verilog/spi_controller.sv
`timescale 1ns/100ps
`default_nettype none

module spi_controller
    import spi_pkg::*;
(
    input  wire logic              S_SYSCLK,
    input  wire logic              S_RESETN,
    input  wire logic [ADDR_W-1:0] awaddr,
    input  wire logic              awvalid,
    output logic                   awready,
    input  wire logic [DATA_W-1:0] wdata,
    input  wire logic [3:0]        wstrb,
    input  wire logic              wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  wire logic              bready,
    input  wire logic [ADDR_W-1:0] araddr,
    input  wire logic              arvalid,
    output logic                   arready,
    output logic [DATA_W-1:0]      rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  wire logic              rready,
    output logic                   spi_sck,
    output logic                   spi_mosi,
    input  wire logic              spi_miso,
    output logic [NCS-1:0]         spi_cs_b
);

    logic                  wr_en, wr_err, rd_en, rd_err;
    logic [ADDR_W-1:0]     wr_addr, rd_addr;
    logic [DATA_W-1:0]     wr_data, rd_data;
    logic [3:0]            wr_strb;
    logic                  tx_push, tx_pop, tx_full, tx_empty;
    logic                  rx_push, rx_pop, rx_full, rx_empty;
    logic [FIFO_LVL_W-1:0] tx_level, rx_level;
    logic [DATA_W-1:0]     tx_word, rx_word, rx_word_out;
    logic                  busy, frame_start, enable, cpol, cpha;
    logic [CS_W-1:0]       cs_sel;
    logic [TRANLEN_W-1:0]  tranlen;
    logic [PM_W-1:0]       pm;
    logic                  char_go, char_done;
    logic [CHAR_W-1:0]     tx_char, rx_char;

    spi_axil_slave u_axil_slave (.*);

    spi_regs u_regs (.*);

    spi_word_fifo u_tx_fifo (
        .S_SYSCLK  (S_SYSCLK),
        .S_RESETN  (S_RESETN),
        .push      (tx_push),
        .push_data (wr_data),
        .pop       (tx_pop),
        .pop_data  (tx_word),
        .full      (tx_full),
        .empty     (tx_empty),
        .level     (tx_level)
    );

    spi_word_fifo u_rx_fifo (
        .S_SYSCLK  (S_SYSCLK),
        .S_RESETN  (S_RESETN),
        .push      (rx_push),
        .push_data (rx_word_out),
        .pop       (rx_pop),
        .pop_data  (rx_word),
        .full      (rx_full),
        .empty     (rx_empty),
        .level     (rx_level)
    );

    spi_frame_ctrl u_frame_ctrl (.*);

    spi_char_shifter u_char_shifter (.*);

endmodule

`default_nettype wire

// File: test/tb_spi_controller.sv
`timescale 1ns/100ps
`default_nettype none

module tb_spi_controller
    import spi_pkg::*;
;
    localparam int MAX_CYCLES = 60000;

    logic              S_SYSCLK, S_RESETN;
    logic [ADDR_W-1:0] awaddr, araddr;
    logic              awvalid, wvalid, bready, arvalid, rready;
    logic [DATA_W-1:0] wdata, rdata;
    logic [3:0]        wstrb;
    logic              awready, wready, bvalid, arready, rvalid;
    logic [1:0]        bresp, rresp;
    logic              spi_sck, spi_mosi, spi_miso;
    logic [NCS-1:0]    spi_cs_b;

    int          errors, test_start_err, cycles, sck_edges, k, b;
    logic [7:0]  tx_bytes[$], miso_bytes[$], mosi_got[$], cur_rx;
    logic [31:0] exp_rx[$];
    logic [NCS-1:0] cs_seen;
    logic        slv_cpol, slv_cpha, lead;

    spi_controller u_spi_controller (.*);

    initial
    begin
        S_SYSCLK = 1'b0;
        forever #10 S_SYSCLK = ~S_SYSCLK;
    end

    // run limit
    always @(posedge S_SYSCLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic miso_bit();
        return (k < miso_bytes.size()) ? miso_bytes[k][7-b] : 1'b0;
    endfunction

    // SPI slave model that restarts at every CS fall
    always @(spi_cs_b)
    begin
        cs_seen = cs_seen | ~spi_cs_b;
        if (spi_cs_b != '1)
        begin
            k = 0;
            b = 0;
            spi_miso <= miso_bit();
        end
    end

    always @(spi_sck)
    begin
        if (spi_cs_b != '1)
        begin
            sck_edges = sck_edges + 1;
            lead = spi_sck != slv_cpol;
            if (lead != slv_cpha)   // sample edge
            begin
                cur_rx = {cur_rx[6:0], spi_mosi};
                b = b + 1;
                if (b == 8)
                begin
                    mosi_got.push_back(cur_rx);
                    k = k + 1;
                    b = 0;
                end
            end
            else
                spi_miso <= miso_bit();
        end
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        @(posedge S_SYSCLK);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(posedge S_SYSCLK); while (!awready);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(posedge S_SYSCLK); while (!bvalid);
        resp = bresp;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(posedge S_SYSCLK);
        araddr  <= addr;
        arvalid <= 1'b1;
        do @(posedge S_SYSCLK); while (!arready);
        arvalid <= 1'b0;
        do @(posedge S_SYSCLK); while (!rvalid);
        data = rdata;
        resp = rresp;
    endtask

    task automatic write_ok(input logic [7:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axi_write(addr, data, 4'hf, resp);
        compare("bresp", resp, RESP_OKAY);
    endtask

    task automatic wait_idle();
        logic [31:0] rd;
        logic [1:0]  resp;
        do axi_read(ADDR_SPSTAT, rd, resp); while (rd[SPSTAT_BUSY]);
    endtask

    // runs one frame and checks the transmit side and CS, then predicts the receive words
    task automatic run_frame(input int cs, input int n, input logic cpol, input logic cpha,
                             input logic [3:0] pm, input logic stall);
        logic [31:0] word;
        int          nwords;
        int          idx;
        nwords = (n + 3) / 4;
        write_ok(ADDR_CSMODE0 + 8'(4 * cs), {cpol, cpha, 10'b0, pm, 16'h0});
        tx_bytes.delete();
        miso_bytes.delete();
        mosi_got.delete();
        exp_rx.delete();
        for (int i = 0; i < n; i++)
        begin
            tx_bytes.push_back(8'($urandom));
            miso_bytes.push_back(8'($urandom));
        end
        slv_cpol = cpol;
        slv_cpha = cpha;
        cs_seen = '0;
        sck_edges = 0;
        write_ok(ADDR_SPCOM, {2'(cs), 26'b0, 4'(n - 1)});
        if (stall)
        begin
            @(posedge S_SYSCLK);
            sck_edges = 0;   // sck takes the new idle level as CS falls
            repeat (299) @(posedge S_SYSCLK);
            compare("spi_cs_b", spi_cs_b, 4'hf ^ (4'b1 << cs));
            if (sck_edges != 0)
            begin
                $display("SCK toggled %0d times with an empty transmit FIFO", sck_edges);
                errors++;
            end
        end
        for (int w = 0; w < nwords; w++)
        begin
            for (int j = 0; j < 4; j++)
            begin
                idx = 4 * w + j;
                word[31-8*j -: 8] = (idx < n) ? tx_bytes[idx] : 8'($urandom);
            end
            write_ok(ADDR_SPITF, word);
        end
        wait_idle();
        if (mosi_got.size() != n)
        begin
            $display("slave captured %0d bytes, expected %0d", mosi_got.size(), n);
            errors++;
        end
        else
        begin
            for (int i = 0; i < n; i++)
                compare("spi_mosi byte", mosi_got[i], tx_bytes[i]);
        end
        compare("cs activity", cs_seen, 4'b1 << cs);
        compare("spi_cs_b", spi_cs_b, 4'hf);
        compare("spi_sck", spi_sck, cpol);   // idle level
        for (int w = 0; w < nwords; w++)
        begin
            word = '0;
            for (int j = 0; j < 4; j++)
            begin
                idx = 4 * w + j;
                if (idx < n)
                    word[31-8*j -: 8] = miso_bytes[idx];
            end
            exp_rx.push_back(word);
        end
    endtask

    task automatic check_rx();
        logic [31:0] rd;
        logic [1:0]  resp;
        axi_read(ADDR_SPSTAT, rd, resp);
        compare("SPSTAT rx level", rd[10:8], exp_rx.size());
        compare("SPSTAT tx level", rd[2:0], 0);
        foreach (exp_rx[i])
        begin
            axi_read(ADDR_SPIRF, rd, resp);
            compare("SPIRF", rd, exp_rx[i]);
            compare("rresp", resp, RESP_OKAY);
        end
        axi_read(ADDR_SPSTAT, rd, resp);
        compare("SPSTAT rx level", rd[10:8], 0);
    endtask

    task automatic end_test(input string name);
        $display("test %s: %s (%0d errors)", name,
                 (errors == test_start_err) ? "ok" : "failing", errors - test_start_err);
        test_start_err = errors;
    endtask

    initial
    begin
        logic [31:0] rd, data, csm[4], spm;
        logic [3:0]  strb;
        logic [1:0]  resp;
        int          r;
        void'($urandom(32'hf037_2ca8));
        errors = 0;
        test_start_err = 0;
        cycles = 0;
        cs_seen = '0;
        slv_cpol = 1'b0;
        slv_cpha = 1'b0;
        S_RESETN <= 1'b0;
        awaddr <= '0;
        awvalid <= 1'b0;
        wdata <= '0;
        wstrb <= '0;
        wvalid <= 1'b0;
        bready <= 1'b1;
        araddr <= '0;
        arvalid <= 1'b0;
        rready <= 1'b1;
        spi_miso <= 1'b0;
        repeat (8) @(posedge S_SYSCLK);
        S_RESETN <= 1'b1;
        @(posedge S_SYSCLK);

        compare("spi_cs_b", spi_cs_b, 4'hf);
        compare("spi_sck", spi_sck, 0);
        compare("valid outputs", {awready, wready, arready, bvalid, rvalid}, 0);
        axi_read(ADDR_SPMODE, rd, resp);
        compare("SPMODE", rd, SPMODE_RST);
        for (int i = 0; i < 4; i++)
        begin
            axi_read(ADDR_CSMODE0 + 8'(4 * i), rd, resp);
            compare("CSMODE", rd, CSMODE_RST);
            csm[i] = CSMODE_RST;
        end
        axi_read(ADDR_SPSTAT, rd, resp);
        compare("SPSTAT", rd, 0);
        spm = SPMODE_RST;
        end_test("reset state");

        for (int t = 0; t < 12; t++)
        begin
            r = $urandom % 5;
            data = $urandom;
            strb = 4'($urandom);
            axi_write((r == 4) ? ADDR_SPMODE : ADDR_CSMODE0 + 8'(4 * r), data, strb, resp);
            compare("bresp", resp, RESP_OKAY);
            for (int j = 0; j < 4; j++)
            begin
                if (strb[j] && r == 4)
                    spm[8*j +: 8] = data[8*j +: 8];
                else if (strb[j])
                    csm[r][8*j +: 8] = data[8*j +: 8];
            end
        end
        axi_read(ADDR_SPMODE, rd, resp);
        compare("SPMODE", rd, spm);
        for (int i = 0; i < 4; i++)
        begin
            axi_read(ADDR_CSMODE0 + 8'(4 * i), rd, resp);
            compare("CSMODE", rd, csm[i]);
            compare("rresp", resp, RESP_OKAY);
        end
        axi_write(8'h14, $urandom, 4'hf, resp);
        compare("bresp unmapped", resp, RESP_SLVERR);
        axi_read(8'h18, rd, resp);
        compare("rresp unmapped", resp, RESP_SLVERR);
        compare("rdata unmapped", rd, 0);
        end_test("register access");

        write_ok(ADDR_SPMODE, SPMODE_RST | 32'h8000_0000);   // enable
        run_frame($urandom % 4, $urandom % 16 + 1, 1'b0, 1'b0, 4'($urandom % 4), 1'b0);
        end_test("mode 0 frame");

        check_rx();
        end_test("receive path");

        for (int m = 0; m < 4; m++)
        begin
            run_frame($urandom % 4, $urandom % 16 + 1, m[1], m[0], 4'($urandom), 1'b0);
            check_rx();
        end
        end_test("clock modes");

        run_frame($urandom % 4, 5, 1'b0, 1'b0, 4'd1, 1'b1);
        check_rx();
        for (int i = 0; i < 4; i++)
            write_ok(ADDR_SPITF, $urandom);
        axi_write(ADDR_SPITF, $urandom, 4'hf, resp);
        compare("bresp SPITF full", resp, RESP_SLVERR);
        axi_read(ADDR_SPSTAT, rd, resp);
        compare("SPSTAT tx level", rd[2:0], 4);
        axi_read(ADDR_SPIRF, rd, resp);
        compare("rresp SPIRF empty", resp, RESP_SLVERR);
        compare("rdata SPIRF empty", rd, 0);
        end_test("back-pressure and errors");

        $display("6 tests run, %0d failed checks", errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
verilog/spi_pkg.sv
verilog/spi_axil_slave.sv
verilog/spi_regs.sv
verilog/spi_word_fifo.sv
verilog/spi_frame_ctrl.sv
verilog/spi_char_shifter.sv
verilog/spi_controller.sv
test/tb_spi_controller.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_spi_controller
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f filelist.f
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
